// ==== Bender.yml ====
package:
  name: rdmx_control

sources:
  - rdmx_ctl_pkg.sv
  - seq_check.sv
  - event_capture.sv
  - ctl_regs.sv
  - read_mux.sv
  - rdmx_control.sv
  - target: test
    files:
      - rdmx_control_checker.sv
      - tb_rdmx_control.sv

// ==== ctl_regs.sv ====
/*
 * Write decode and configuration registers
 * PCI buffer window, loopback, counter clear strobe
 * Soft-reset and PCI pause countdowns
 */
`default_nettype none

module ctl_regs (
    input  logic                   clk,
    input  logic                   resetn,
    input  rdmx_ctl_pkg::reg_wr_t  reg_wr,
    output logic                   wr_done,
    output rdmx_ctl_pkg::resp_e    wr_resp,
    output rdmx_ctl_pkg::pci_cfg_t pci,
    output logic                   loopback,
    output logic                   pause_pci,
    output logic                   resetn_out,
    output logic                   counter_clear
);
    import rdmx_ctl_pkg::*;

    logic [RST_CNT_W-1:0]  reset_count;
    logic [REG_DATA_W-1:0] pause_count;
    logic                  reset_active;
    logic                  clear_hit;
    logic                  index_ok;

    // Downstream held in reset by the input reset or the countdown
    assign reset_active = !resetn || (reset_count != '0);
    assign resetn_out   = !reset_active;

    assign pause_pci = (pause_count != '0);

    // Clear lands on the strobe edge so the next read sees zero
    assign clear_hit     = reg_wr.valid && (reg_wr.index == REG_CLEAR);
    assign counter_clear = reset_active || clear_hit;

    // Writable indexes
    always_comb begin
        case (reg_wr.index)
            REG_PCI_BASE_H, REG_PCI_BASE_L,
            REG_PCI_SIZE_H, REG_PCI_SIZE_L,
            REG_RESET, REG_CLEAR,
            REG_LOOPBACK, REG_PAUSE_PCI: index_ok = 1'b1;
            default:                     index_ok = 1'b0;
        endcase
    end

    // ============================
    // Write acknowledge
    // ============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= reg_wr.valid;
        end
    end

    // Read-only and unmapped indexes give a decode error
    always_ff @(posedge clk) begin
        if (reg_wr.valid) begin
            wr_resp <= index_ok ? RESP_OKAY : RESP_DECERR;
        end
    end

    // ============================
    // Registers and countdowns
    // ============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pci.base    <= PCI_BASE_RST;
            pci.size    <= PCI_SIZE_RST;
            loopback    <= 1'b0;
            pause_count <= '0;
            reset_count <= '0;
        end else begin
            // Count down, a new write below takes priority
            if (reset_count != '0) begin
                reset_count <= reset_count - 1'b1;
            end
            if (pause_count != '0) begin
                pause_count <= pause_count - 1'b1;
            end

            if (reg_wr.valid) begin
                case (reg_wr.index)
                    REG_PCI_BASE_H: pci.base[CNT_W-1 -: REG_DATA_W] <= reg_wr.data;
                    REG_PCI_BASE_L: pci.base[REG_DATA_W-1:0]        <= reg_wr.data;
                    REG_PCI_SIZE_H: pci.size[CNT_W-1 -: REG_DATA_W] <= reg_wr.data;
                    REG_PCI_SIZE_L: pci.size[REG_DATA_W-1:0]        <= reg_wr.data;
                    REG_LOOPBACK:   loopback    <= reg_wr.data[0];
                    REG_RESET:      reset_count <= RST_CNT_W'(RESET_HOLD_CYCLES);
                    // N written gives N cycles of pause
                    REG_PAUSE_PCI:  pause_count <= reg_wr.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== event_capture.sv ====
/*
 * Input side event capture
 * Two-flop synchronisers for the async status bits
 * Good and bad packet counters and the sticky PCI range error
 */
`default_nettype none

module event_capture (
    input  logic                              clk,
    input  logic                              counter_clear,
    input  rdmx_ctl_pkg::pkt_event_t          events,
    input  rdmx_ctl_pkg::async_status_t       async_status,
    output logic [rdmx_ctl_pkg::CNT_W-1:0]    good_count,
    output logic [rdmx_ctl_pkg::CNT_W-1:0]    bad_count,
    output logic                              range_err,
    output rdmx_ctl_pkg::async_status_t       status
);
    import rdmx_ctl_pkg::*;

    // ============================
    // Status synchronisers
    // ============================
    // First stage may go metastable
    async_status_t sync_meta;
    async_status_t sync_q;

    always_ff @(posedge clk) begin
        sync_meta <= async_status;
        sync_q    <= sync_meta;
    end

    assign status = sync_q;

    // ============================
    // Counters and sticky flag
    // ============================
    always_ff @(posedge clk) begin
        if (counter_clear) begin
            good_count <= '0;
            bad_count  <= '0;
            range_err  <= 1'b0;
        end else begin
            // One count per strobe cycle
            if (events.good) begin
                good_count <= good_count + 1'b1;
            end
            if (events.bad) begin
                bad_count <= bad_count + 1'b1;
            end
            // Stays set until the next clear
            if (events.range_err) begin
                range_err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rdmx_control.f ====
rdmx_ctl_pkg.sv
seq_check.sv
event_capture.sv
ctl_regs.sv
read_mux.sv
rdmx_control.sv
rdmx_control_checker.sv
tb_rdmx_control.sv

// ==== rdmx_control.sv ====
/*
 * Control and status block for the packet-capture datapath
 * Input side, write decode and read mux joined through the status view
 */
`default_nettype none

module rdmx_control (
    input  logic                        clk,
    input  logic                        resetn,
    input  rdmx_ctl_pkg::reg_wr_t       reg_wr,
    output logic                        wr_done,
    output rdmx_ctl_pkg::resp_e         wr_resp,
    input  rdmx_ctl_pkg::reg_rd_req_t   reg_rd_req,
    output rdmx_ctl_pkg::reg_rd_t       reg_rd,
    input  rdmx_ctl_pkg::pkt_event_t    events,
    input  logic [1:0]                  overflow,
    input  rdmx_ctl_pkg::async_status_t async_status,
    input  rdmx_ctl_pkg::stream_beat_t  stream,
    output rdmx_ctl_pkg::pci_cfg_t      pci,
    output logic                        loopback,
    output logic                        pause_pci,
    output logic                        resetn_out
);
    import rdmx_ctl_pkg::*;

    logic             counter_clear;
    logic             seq_error;
    logic             range_err;
    logic [CNT_W-1:0] good_count;
    logic [CNT_W-1:0] bad_count;
    async_status_t    sync_status;
    status_view_t     view;

    // ============================
    // Input side
    // ============================
    seq_check u_seq_check (
        .clk           (clk),
        .counter_clear (counter_clear),
        .stream        (stream),
        .seq_error     (seq_error)
    );

    event_capture u_event_capture (
        .clk           (clk),
        .counter_clear (counter_clear),
        .events        (events),
        .async_status  (async_status),
        .good_count    (good_count),
        .bad_count     (bad_count),
        .range_err     (range_err),
        .status        (sync_status)
    );

    // Register writes, countdowns and the clear strobe
    ctl_regs u_ctl_regs (
        .clk           (clk),
        .resetn        (resetn),
        .reg_wr        (reg_wr),
        .wr_done       (wr_done),
        .wr_resp       (wr_resp),
        .pci           (pci),
        .loopback      (loopback),
        .pause_pci     (pause_pci),
        .resetn_out    (resetn_out),
        .counter_clear (counter_clear)
    );

    // Overflow levels pass straight into the error word
    assign view = '{
        good:         good_count,
        bad:          bad_count,
        errors:       {seq_error, overflow, range_err},
        status:       {sync_status.ddr_cal, sync_status.pcs_aligned},
        reset_active: !resetn_out,
        pause_active: pause_pci,
        loopback:     loopback,
        pci:          pci
    };

    // ============================
    // Output side
    // ============================
    read_mux u_read_mux (
        .clk        (clk),
        .resetn     (resetn),
        .reg_rd_req (reg_rd_req),
        .view       (view),
        .reg_rd     (reg_rd)
    );

endmodule

`default_nettype wire

// ==== rdmx_control_checker.sv ====
/*
 * Bound assertions for the control block
 * Strobe-to-reply timing and reset state of pause and loopback
 */
`default_nettype none

module rdmx_control_checker (
    input logic                      clk,
    input logic                      resetn,
    input rdmx_ctl_pkg::reg_wr_t     reg_wr,
    input logic                      wr_done,
    input rdmx_ctl_pkg::reg_rd_req_t reg_rd_req,
    input rdmx_ctl_pkg::reg_rd_t     reg_rd,
    input logic                      pause_pci,
    input logic                      loopback
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far
    int fail_count = 0;

    // Write acknowledge one cycle after the strobe
    wr_ack: assert property (@(posedge clk) disable iff (!resetn) reg_wr.valid |=> wr_done)
        else begin
            $error("wr_done missing one cycle after a write strobe");
            fail_count++;
        end

    rd_reply: assert property (@(posedge clk) disable iff (!resetn)
                               reg_rd_req.valid |=> reg_rd.valid)
        else begin
            $error("reg_rd.valid missing one cycle after a read strobe");
            fail_count++;
        end

    // Outputs idle right after reset
    rst_idle: assert property (@(posedge clk) !resetn |=> (!pause_pci && !loopback))
        else begin
            $error("pause_pci or loopback high after reset");
            fail_count++;
        end

endmodule

bind rdmx_control rdmx_control_checker u_checker (
    .clk        (clk),
    .resetn     (resetn),
    .reg_wr     (reg_wr),
    .wr_done    (wr_done),
    .reg_rd_req (reg_rd_req),
    .reg_rd     (reg_rd),
    .pause_pci  (pause_pci),
    .loopback   (loopback)
);

`default_nettype wire

// ==== rdmx_ctl_pkg.sv ====
/*
 * Shared definitions for the capture control block
 * Register map, response codes, widths and reset values
 * Packed structs for the host strobes, events, stream and status view
 */
`default_nettype none

package rdmx_ctl_pkg;

    // ============================
    // Widths and constants
    // ============================
    localparam int REG_DATA_W = 32;
    localparam int CNT_W      = 64;
    localparam int REG_IDX_W  = 8;
    localparam int TDATA_W    = 512;
    // Sequence counter sits in the top bits of each beat
    localparam int SEQ_W      = 32;

    // Soft-reset length in clocks
    localparam int RESET_HOLD_CYCLES = 1000;
    localparam int RST_CNT_W         = $clog2(RESET_HOLD_CYCLES + 1);

    // Default host buffer is 4 GB at the 4 GB mark
    localparam logic [CNT_W-1:0] PCI_BASE_RST = 64'h1_0000_0000;
    localparam logic [CNT_W-1:0] PCI_SIZE_RST = 64'h1_0000_0000;

    // ============================
    // Register map and responses
    // ============================
    typedef enum logic [REG_IDX_W-1:0] {
        REG_STATUS     = 8'd0,
        REG_ERRORS     = 8'd1,
        REG_GOOD_H     = 8'd2,
        REG_GOOD_L     = 8'd3,
        REG_BAD_H      = 8'd4,
        REG_BAD_L      = 8'd5,
        REG_PCI_BASE_H = 8'd6,
        REG_PCI_BASE_L = 8'd7,
        REG_PCI_SIZE_H = 8'd8,
        REG_PCI_SIZE_L = 8'd9,
        REG_RESET      = 8'd10,
        REG_CLEAR      = 8'd11,
        REG_LOOPBACK   = 8'd34,
        REG_PAUSE_PCI  = 8'd35
    } reg_index_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    // ============================
    // Packed structs
    // ============================
    // Host write strobe, one cycle
    typedef struct packed {
        logic                  valid;
        logic [REG_IDX_W-1:0]  index;
        logic [REG_DATA_W-1:0] data;
    } reg_wr_t;

    // Host read strobe, one cycle
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] index;
    } reg_rd_req_t;

    // Read reply
    typedef struct packed {
        logic                  valid;
        logic [REG_DATA_W-1:0] data;
        resp_e                 resp;
    } reg_rd_t;

    // Per-packet strobes from the capture path
    typedef struct packed {
        logic good;
        logic bad;
        logic range_err;
    } pkt_event_t;

    typedef struct packed {
        logic [1:0] ddr_cal;
        logic       pcs_aligned;
    } async_status_t;

    // Monitored AXI-Stream beat
    typedef struct packed {
        logic [TDATA_W-1:0] tdata;
        logic               tvalid;
        logic               tready;
        logic               tlast;
    } stream_beat_t;

    typedef struct packed {
        logic [CNT_W-1:0] base;
        logic [CNT_W-1:0] size;
    } pci_cfg_t;

    // Everything the read side can return
    typedef struct packed {
        logic [CNT_W-1:0] good;
        logic [CNT_W-1:0] bad;
        // seq_error, overflow_1, overflow_0, range_err
        logic [3:0]       errors;
        // ddr_cal[1:0], pcs_aligned
        logic [2:0]       status;
        logic             reset_active;
        logic             pause_active;
        logic             loopback;
        pci_cfg_t         pci;
    } status_view_t;

endpackage

`default_nettype wire

// ==== read_mux.sv ====
/*
 * Registered read decode
 * Selects one word of the status view and returns it with a response
 */
`default_nettype none

module read_mux (
    input  logic                       clk,
    input  logic                       resetn,
    input  rdmx_ctl_pkg::reg_rd_req_t  reg_rd_req,
    input  rdmx_ctl_pkg::status_view_t view,
    output rdmx_ctl_pkg::reg_rd_t      reg_rd
);
    import rdmx_ctl_pkg::*;

    logic [REG_DATA_W-1:0] sel_data;
    resp_e                 sel_resp;
    logic                  rd_valid;
    logic [REG_DATA_W-1:0] rd_data;
    resp_e                 rd_resp;

    // Word select, unmapped indexes read as zero
    always_comb begin
        sel_data = '0;
        sel_resp = RESP_OKAY;
        case (reg_rd_req.index)
            REG_STATUS:     sel_data = REG_DATA_W'(view.status);
            REG_ERRORS:     sel_data = REG_DATA_W'(view.errors);
            REG_GOOD_H:     sel_data = view.good[CNT_W-1 -: REG_DATA_W];
            REG_GOOD_L:     sel_data = view.good[REG_DATA_W-1:0];
            REG_BAD_H:      sel_data = view.bad[CNT_W-1 -: REG_DATA_W];
            REG_BAD_L:      sel_data = view.bad[REG_DATA_W-1:0];
            REG_PCI_BASE_H: sel_data = view.pci.base[CNT_W-1 -: REG_DATA_W];
            REG_PCI_BASE_L: sel_data = view.pci.base[REG_DATA_W-1:0];
            REG_PCI_SIZE_H: sel_data = view.pci.size[CNT_W-1 -: REG_DATA_W];
            REG_PCI_SIZE_L: sel_data = view.pci.size[REG_DATA_W-1:0];
            // Single-bit registers
            REG_RESET:      sel_data = REG_DATA_W'(view.reset_active);
            REG_LOOPBACK:   sel_data = REG_DATA_W'(view.loopback);
            REG_PAUSE_PCI:  sel_data = REG_DATA_W'(view.pause_active);
            default:        sel_resp = RESP_DECERR;
        endcase
    end

    // ============================
    // Reply registers
    // ============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= reg_rd_req.valid;
        end
    end

    // Payload only moves on a request
    always_ff @(posedge clk) begin
        if (reg_rd_req.valid) begin
            rd_data <= sel_data;
            rd_resp <= sel_resp;
        end
    end

    assign reg_rd = '{valid: rd_valid, data: rd_data, resp: rd_resp};

endmodule

`default_nettype wire

// ==== seq_check.sv ====
/*
 * Stream sequence monitor
 * Flags a sticky error when the counter in the top bits of a beat breaks
 */
`default_nettype none

module seq_check (
    input  logic                       clk,
    input  logic                       counter_clear,
    input  rdmx_ctl_pkg::stream_beat_t stream,
    output logic                       seq_error
);
    import rdmx_ctl_pkg::*;

    // Counter field of the current beat
    logic [SEQ_W-1:0] seq_field;
    // Field seen on the previous accepted beat
    logic [SEQ_W-1:0] seq_prior;
    logic             beat;

    assign seq_field = stream.tdata[TDATA_W-1 -: SEQ_W];

    // Only accepted beats count
    assign beat = stream.tvalid && stream.tready;

    always_ff @(posedge clk) begin
        if (counter_clear) begin
            seq_error <= 1'b0;
            seq_prior <= '0;
        end else if (beat) begin
            // Zero field means no counter on this beat
            if ((seq_field != '0) && (seq_field != seq_prior + 1'b1)) begin
                seq_error <= 1'b1;
            end
            seq_prior <= seq_field;
        end
    end

endmodule

`default_nettype wire

// ==== tb_rdmx_control.sv ====
/*
 * Testbench for the capture control block
 * Register model with a reference read function and typed compare tasks
 * Covers PCI window, decode errors, counters, error flags, countdowns, status
 */
`default_nettype none

module tb_rdmx_control;
    timeunit 1ns;
    timeprecision 1ps;
    import rdmx_ctl_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk;
    logic          resetn;
    reg_wr_t       reg_wr;
    logic          wr_done;
    resp_e         wr_resp;
    reg_rd_req_t   reg_rd_req;
    reg_rd_t       reg_rd;
    pkt_event_t    events;
    logic [1:0]    overflow;
    async_status_t async_status;
    stream_beat_t  stream;
    pci_cfg_t      pci;
    logic          loopback;
    logic          pause_pci;
    logic          resetn_out;

    // ==============================
    // Register model
    // ==============================
    logic [CNT_W-1:0] m_base;
    logic [CNT_W-1:0] m_size;
    logic             m_loopback;
    logic [CNT_W-1:0] m_good;
    logic [CNT_W-1:0] m_bad;
    logic             m_range;
    logic             m_seq_err;
    logic [1:0]       m_overflow;
    logic [2:0]       m_status;
    // Countdown bits as a read sees them
    logic             m_reset_act;
    logic             m_pause_act;

    // Expected replies in issue order
    logic [REG_DATA_W-1:0] exp_data_q[$];
    resp_e                 exp_resp_q[$];
    logic [REG_IDX_W-1:0]  exp_idx_q[$];

    rdmx_control i_rdmx_control (
        .clk          (clk),
        .resetn       (resetn),
        .reg_wr       (reg_wr),
        .wr_done      (wr_done),
        .wr_resp      (wr_resp),
        .reg_rd_req   (reg_rd_req),
        .reg_rd       (reg_rd),
        .events       (events),
        .overflow     (overflow),
        .async_status (async_status),
        .stream       (stream),
        .pci          (pci),
        .loopback     (loopback),
        .pause_pci    (pause_pci),
        .resetn_out   (resetn_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [REG_DATA_W-1:0] got,
                              input logic [REG_DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input resp_e got, input resp_e exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    function automatic logic is_mapped(input logic [REG_IDX_W-1:0] idx);
        return (idx <= REG_CLEAR) || (idx == REG_LOOPBACK) || (idx == REG_PAUSE_PCI);
    endfunction

    // Expected word and response for a read of idx
    function automatic logic [REG_DATA_W-1:0] ref_read(input logic [REG_IDX_W-1:0] idx,
                                                       output resp_e resp);
        logic [REG_DATA_W-1:0] word;
        word = '0;
        resp = RESP_OKAY;
        case (idx)
            REG_STATUS:     word = REG_DATA_W'(m_status);
            REG_ERRORS:     word = REG_DATA_W'({m_seq_err, m_overflow, m_range});
            REG_GOOD_H:     word = m_good[63:32];
            REG_GOOD_L:     word = m_good[31:0];
            REG_BAD_H:      word = m_bad[63:32];
            REG_BAD_L:      word = m_bad[31:0];
            REG_PCI_BASE_H: word = m_base[63:32];
            REG_PCI_BASE_L: word = m_base[31:0];
            REG_PCI_SIZE_H: word = m_size[63:32];
            REG_PCI_SIZE_L: word = m_size[31:0];
            REG_LOOPBACK:   word = REG_DATA_W'(m_loopback);
            REG_RESET:      word = REG_DATA_W'(m_reset_act);
            REG_PAUSE_PCI:  word = REG_DATA_W'(m_pause_act);
            default:        resp = RESP_DECERR;
        endcase
        return word;
    endfunction

    // Model side of a write
    task automatic model_write(input logic [REG_IDX_W-1:0] idx,
                               input logic [REG_DATA_W-1:0] data, output resp_e resp);
        resp = RESP_OKAY;
        case (idx)
            REG_PCI_BASE_H: m_base[63:32] = data;
            REG_PCI_BASE_L: m_base[31:0]  = data;
            REG_PCI_SIZE_H: m_size[63:32] = data;
            REG_PCI_SIZE_L: m_size[31:0]  = data;
            REG_LOOPBACK:   m_loopback    = data[0];
            REG_RESET, REG_CLEAR: begin
                m_good    = '0;
                m_bad     = '0;
                m_range   = 1'b0;
                m_seq_err = 1'b0;
            end
            REG_PAUSE_PCI: ;
            default:        resp = RESP_DECERR;
        endcase
    endtask

    // ==============================
    // Host strobes
    // ==============================
    task automatic write_reg(input logic [REG_IDX_W-1:0] idx, input logic [REG_DATA_W-1:0] data);
        resp_e exp_resp;
        int    waited;
        model_write(idx, data, exp_resp);
        @(posedge clk);
        reg_wr <= '{valid: 1'b1, index: idx, data: data};
        @(posedge clk);
        reg_wr <= '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_on_error("timeout waiting for wr_done");
        end while (wr_done !== 1'b1);
        check_resp("wr_resp", wr_resp, exp_resp);
    endtask

    // Compare happens in the reply process below
    task automatic read_reg(input logic [REG_IDX_W-1:0] idx);
        logic [REG_DATA_W-1:0] data;
        resp_e                 resp;
        int                    waited;
        data = ref_read(idx, resp);
        exp_data_q.push_back(data);
        exp_resp_q.push_back(resp);
        exp_idx_q.push_back(idx);
        @(posedge clk);
        reg_rd_req <= '{valid: 1'b1, index: idx};
        @(posedge clk);
        reg_rd_req <= '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) stop_on_error("timeout waiting for reg_rd.valid");
        end while (reg_rd.valid !== 1'b1);
    endtask

    // Random train of good and bad strobes
    task automatic send_events(input int cycles);
        pkt_event_t ev;
        repeat (cycles) begin
            ev      = '0;
            ev.good = 1'($urandom_range(1, 0));
            ev.bad  = 1'($urandom_range(1, 0));
            @(posedge clk);
            events <= ev;
            m_good = m_good + ev.good;
            m_bad  = m_bad + ev.bad;
        end
        @(posedge clk);
        events <= '0;
    endtask

    task automatic send_beat(input logic [SEQ_W-1:0] field, input logic ready);
        stream_beat_t beat;
        beat        = '0;
        beat.tdata[TDATA_W-1 -: SEQ_W] = field;
        beat.tdata[31:0] = $urandom();
        beat.tvalid = 1'b1;
        beat.tready = ready;
        @(posedge clk);
        stream <= beat;
    endtask

    // Counts negedges while a level holds, starting at the current one
    task automatic measure_level(input string name, input logic level, input int exp);
        int count;
        count = 0;
        while ((level ? pause_pci : !resetn_out) === 1'b1) begin
            count++;
            if (count > TIMEOUT_CYCLES) stop_on_error({name, " never returned to idle"});
            @(negedge clk);
        end
        check_word({name, " cycles"}, REG_DATA_W'(count), REG_DATA_W'(exp));
    endtask

    // ==============================
    // Reply compare
    // ==============================
    always @(negedge clk) begin
        logic [REG_IDX_W-1:0] idx;
        if (resetn === 1'b1 && reg_rd.valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                stop_on_error("read reply arrived with no read outstanding");
            end else begin
                idx = exp_idx_q.pop_front();
                check_word($sformatf("reg_rd.data[%0d]", idx), reg_rd.data,
                           exp_data_q.pop_front());
                check_resp($sformatf("reg_rd.resp[%0d]", idx), reg_rd.resp,
                           exp_resp_q.pop_front());
            end
        end
    end

    // Bound assertions raise this count
    always @(posedge clk) begin
        if (i_rdmx_control.u_checker.fail_count != 0) begin
            stop_on_error("a bound assertion on rdmx_control failed");
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic [REG_IDX_W-1:0] idx;
        async_status_t        stat;
        int                   n;
        void'($urandom(32'h8605));
        resetn       = 1'b0;
        reg_wr       = '0;
        reg_rd_req   = '0;
        events       = '0;
        overflow     = '0;
        async_status = '0;
        stream       = '0;
        m_base       = PCI_BASE_RST;
        m_size       = PCI_SIZE_RST;
        m_loopback   = 1'b0;
        m_good       = '0;
        m_bad        = '0;
        m_range      = 1'b0;
        m_seq_err    = 1'b0;
        m_overflow   = '0;
        m_status     = '0;
        m_reset_act  = 1'b0;
        m_pause_act  = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        // Reset values then random PCI window and loopback
        for (int i = REG_PCI_BASE_H; i <= REG_PCI_SIZE_L; i++) read_reg(REG_IDX_W'(i));
        for (int i = REG_PCI_BASE_H; i <= REG_PCI_SIZE_L; i++) begin
            write_reg(REG_IDX_W'(i), $urandom());
            read_reg(REG_IDX_W'(i));
        end
        check_word("pci.base[63:32]", pci.base[63:32], m_base[63:32]);
        check_word("pci.base[31:0]", pci.base[31:0], m_base[31:0]);
        check_word("pci.size[63:32]", pci.size[63:32], m_size[63:32]);
        check_word("pci.size[31:0]", pci.size[31:0], m_size[31:0]);
        repeat (4) begin
            write_reg(REG_LOOPBACK, $urandom());
            read_reg(REG_LOOPBACK);
            check_bit("loopback", loopback, m_loopback);
        end

        // Unmapped indexes, nothing else may move
        repeat (8) begin
            do idx = REG_IDX_W'($urandom_range(255, 0)); while (is_mapped(idx));
            write_reg(idx, $urandom());
            read_reg(idx);
        end
        read_reg(REG_PCI_BASE_L);
        read_reg(REG_PCI_SIZE_H);

        // Packet counters
        repeat (3) begin
            send_events($urandom_range(64, 16));
            read_reg(REG_GOOD_H);
            read_reg(REG_GOOD_L);
            read_reg(REG_BAD_H);
            read_reg(REG_BAD_L);
        end
        write_reg(REG_CLEAR, '0);
        read_reg(REG_GOOD_L);
        read_reg(REG_BAD_L);

        // Error flags, range first
        @(posedge clk);
        events <= '{good: 1'b0, bad: 1'b0, range_err: 1'b1};
        m_range = 1'b1;
        @(posedge clk);
        events <= '0;
        read_reg(REG_ERRORS);
        for (int lvl = 1; lvl <= 2; lvl++) begin
            @(posedge clk);
            overflow <= 2'(lvl);
            m_overflow = 2'(lvl);
            read_reg(REG_ERRORS);
        end

        // Counting field with one stalled beat keeps bit 3 clear
        for (int s = 1; s <= 20; s++) send_beat(SEQ_W'(s), 1'b1);
        send_beat(SEQ_W'(999), 1'b0);
        for (int s = 21; s <= 24; s++) send_beat(SEQ_W'(s), 1'b1);
        @(posedge clk);
        stream <= '0;
        read_reg(REG_ERRORS);
        // Skip 25
        send_beat(SEQ_W'(26), 1'b1);
        m_seq_err = 1'b1;
        @(posedge clk);
        stream <= '0;
        read_reg(REG_ERRORS);
        @(posedge clk);
        overflow <= 2'b11;
        m_overflow = 2'b11;
        write_reg(REG_CLEAR, '0);
        read_reg(REG_ERRORS);
        @(posedge clk);
        overflow <= 2'b00;
        m_overflow = 2'b00;

        // Pause and soft-reset countdowns
        // A pause of two or more cycles is still running when the read samples it
        n = $urandom_range(40, 2);
        check_bit("pause_pci", pause_pci, 1'b0);
        write_reg(REG_PAUSE_PCI, REG_DATA_W'(n));
        m_pause_act = 1'b1;
        fork
            measure_level("pause_pci", 1'b1, n);
            read_reg(REG_PAUSE_PCI);
        join
        m_pause_act = 1'b0;
        read_reg(REG_PAUSE_PCI);
        send_events(20);
        check_bit("resetn_out", resetn_out, 1'b1);
        write_reg(REG_RESET, 32'd1);
        m_reset_act = 1'b1;
        fork
            measure_level("resetn_out low", 1'b0, RESET_HOLD_CYCLES);
            read_reg(REG_RESET);
        join
        m_reset_act = 1'b0;
        read_reg(REG_RESET);
        read_reg(REG_GOOD_L);
        read_reg(REG_BAD_L);
        read_reg(REG_ERRORS);

        // Synchronised status, two flops of latency
        repeat (4) begin
            stat = async_status_t'($urandom());
            @(posedge clk);
            async_status <= stat;
            m_status = stat;
            repeat (4) @(posedge clk);
            read_reg(REG_STATUS);
        end

        repeat (4) @(posedge clk);
        if (exp_data_q.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("read replies still outstanding at end of run");
        end
    end

endmodule

`default_nettype wire
